/* Bender.yml */
package:
  name: rs_serial

sources:
  # Package first, then the blocks, then the top level
  - design/rs_pkg.sv
  - design/rs_prio_enc.sv
  - design/rs_entry.sv
  - design/rs_dispatch.sv
  - design/rs_writeback.sv
  - design/rs_serial_top.sv

  # Testbench: unit model and top
  - target: test
    files:
      - bench/tb_serial_eu.sv
      - bench/tb_rs_serial.sv

/* bench/tb_rs_serial.sv */
// ----------------------------------------------------------
// Testbench for the serial-unit reservation station. Drives
// issue and CDB traffic, answers dispatches with a model unit
// and checks the station with concurrent assertions.
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_rs_serial import rs_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 3000;  // About three times the test lengths
  localparam int WAIT_LIMIT     = 100;   // Per handshake
  localparam int SEED           = 82;
  localparam int N_TAGS         = 2 ** ROB_IDX_W;

  logic         clk_i, rst_ni, flush_i;
  logic         issue_valid_i, issue_ready_o;
  eu_ctl_t      issue_eu_ctl_i;
  logic         issue_rs1_ready_i, issue_rs2_ready_i;
  rob_idx_t     issue_rs1_rob_idx_i, issue_rs2_rob_idx_i, issue_dest_rob_idx_i;
  xlen_t        issue_rs1_value_i, issue_rs2_value_i;
  logic         cdb_valid_i, cdb_ready_i;
  rob_idx_t     cdb_rob_idx_i;
  xlen_t        cdb_value_i;
  logic         cdb_valid_o, cdb_except_raised_o;
  rob_idx_t     cdb_rob_idx_o;
  xlen_t        cdb_value_o;
  except_code_t cdb_except_code_o;
  logic         eu_ready_i, eu_valid_o;
  eu_ctl_t      eu_ctl_o;
  xlen_t        eu_rs1_o, eu_rs2_o;
  rob_idx_t     eu_rob_idx_o;
  logic         eu_valid_i, eu_except_raised_i;
  rob_idx_t     eu_rob_idx_i;
  xlen_t        eu_result_i;
  except_code_t eu_except_code_i;

  // Scoreboard, indexed by ROB tag
  xlen_t        exp_value [N_TAGS];
  logic         exp_exc   [N_TAGS];
  except_code_t exp_code  [N_TAGS];
  logic         exp_live  [N_TAGS];
  logic         wb_seen   [N_TAGS];

  int   seed, occ, cycle_cnt;
  int   errors, errors_before, tests_run, tests_failed;
  logic wake_hold, hold_check;

  always #2 clk_i = ~clk_i;

  rs_serial_top u_rs_serial_top (.*);

  tb_serial_eu #(.SEED(SEED)) u_eu (
    .clk_i, .rst_ni, .flush_i,
    .req_valid_i     (eu_valid_o),
    .req_ready_o     (eu_ready_i),
    .ctl_i           (eu_ctl_o),
    .rs1_i           (eu_rs1_o),
    .rs2_i           (eu_rs2_o),
    .rob_idx_i       (eu_rob_idx_o),
    .res_valid_o     (eu_valid_i),
    .res_rob_idx_o   (eu_rob_idx_i),
    .res_value_o     (eu_result_i),
    .except_raised_o (eu_except_raised_i),
    .except_code_o   (eu_except_code_i)
  );

  // ----------------------------------------------------------
  // Occupancy and scoreboard bookkeeping
  // ----------------------------------------------------------
  always @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      occ <= 0;
      for (int t = 0; t < N_TAGS; t++) begin
        exp_live[t] <= 1'b0;
      end
    end else begin
      occ <= occ + int'(issue_valid_i && issue_ready_o) - int'(cdb_valid_o && cdb_ready_i);
      if (cdb_valid_o && cdb_ready_i) begin
        exp_live[cdb_rob_idx_o] <= 1'b0;   // Tag retired
        wb_seen[cdb_rob_idx_o]  <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------
  a_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> issue_ready_o && !eu_valid_o && !cdb_valid_o)
    else begin
      $display("FAILED %0t: station not idle after reset", $time);
      errors++;
    end

  a_ready_level: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_ready_o == (occ != RS_DEPTH))
    else begin
      $display("FAILED %0t: issue_ready_o wrong for %0d occupied entries", $time, occ);
      errors++;
    end

  a_ready_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i && issue_ready_o && issue_rs1_ready_i && issue_rs2_ready_i && !flush_i
    |=> eu_valid_o)
    else begin
      $display("FAILED %0t: no execute request after ready issue", $time);
      errors++;
    end

  a_wb_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cdb_valid_o && cdb_ready_i |-> exp_live[cdb_rob_idx_o] === 1'b1
      && cdb_value_o === exp_value[cdb_rob_idx_o]
      && cdb_except_raised_o === exp_exc[cdb_rob_idx_o]
      && cdb_except_code_o === exp_code[cdb_rob_idx_o])
    else begin
      $display("FAILED %0t: bad writeback for tag %0d", $time, cdb_rob_idx_o);
      errors++;
    end

  a_wake_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wake_hold |-> !eu_valid_o)
    else begin
      $display("FAILED %0t: execute request before operands arrived", $time);
      errors++;
    end

  a_cdb_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold_check && cdb_valid_o && !cdb_ready_i && !flush_i |=> cdb_valid_o
      && $stable(cdb_rob_idx_o) && $stable(cdb_value_o)
      && $stable(cdb_except_raised_o) && $stable(cdb_except_code_o))
    else begin
      $display("FAILED %0t: CDB output moved under back-pressure", $time);
      errors++;
    end

  a_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flush_i |=> !eu_valid_o && !cdb_valid_o && issue_ready_o)
    else begin
      $display("FAILED %0t: station not empty after flush", $time);
      errors++;
    end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic xlen_t rand_word();
    return xlen_t'($random(seed));
  endfunction

  function automatic xlen_t expected_result(input eu_ctl_t ctl, input xlen_t a, input xlen_t b);
    return ctl[0] ? a - b : a + b;
  endfunction

  // a and b are the values the operands end up with, forwarded or not
  task automatic issue_instr(input eu_ctl_t ctl, input rob_idx_t dest,
                             input logic r1_rdy, input rob_idx_t r1_tag, input xlen_t a,
                             input logic r2_rdy, input rob_idx_t r2_tag, input xlen_t b);
    int waited;
    waited          = 0;
    exp_value[dest] = expected_result(ctl, a, b);
    exp_exc[dest]   = ctl == 4'hf;
    exp_code[dest]  = (ctl == 4'hf) ? 5'd2 : 5'd0;
    exp_live[dest]  = 1'b1;
    wb_seen[dest]   = 1'b0;
    @(posedge clk_i);
    issue_valid_i        <= 1'b1;
    issue_eu_ctl_i       <= ctl;
    issue_dest_rob_idx_i <= dest;
    issue_rs1_ready_i    <= r1_rdy;
    issue_rs1_rob_idx_i  <= r1_tag;
    issue_rs1_value_i    <= r1_rdy ? a : rand_word();
    issue_rs2_ready_i    <= r2_rdy;
    issue_rs2_rob_idx_i  <= r2_tag;
    issue_rs2_value_i    <= r2_rdy ? b : rand_word();
    @(posedge clk_i);
    while (issue_ready_o !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    issue_valid_i <= 1'b0;
    if (waited >= WAIT_LIMIT) begin
      $display("Issue of tag %0d was never accepted", dest);
      errors++;
    end
  endtask

  task automatic broadcast(input rob_idx_t tag, input xlen_t value);
    @(posedge clk_i);
    cdb_valid_i   <= 1'b1;
    cdb_rob_idx_i <= tag;
    cdb_value_i   <= value;
    @(posedge clk_i);
    cdb_valid_i   <= 1'b0;
  endtask

  task automatic wait_writeback(input rob_idx_t tag);
    int waited;
    waited = 0;
    while (wb_seen[tag] !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (wb_seen[tag] !== 1'b1) begin
      $display("Tag %0d was never written back", tag);
      errors++;
    end
  endtask

  task automatic wait_cdb_valid();
    int waited;
    waited = 0;
    while (cdb_valid_o !== 1'b1 && waited < WAIT_LIMIT) begin
      @(posedge clk_i);
      waited++;
    end
    if (cdb_valid_o !== 1'b1) begin
      $display("CDB output never became valid");
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d check(s) failed", tests_run, name, errors - errors_before);
    end
    errors_before = errors;
  endtask

  // ----------------------------------------------------------
  // Tests
  // ----------------------------------------------------------
  initial begin
    xlen_t wake_a, wake_b;
    seed = SEED;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_eu_ctl_i = '0;
    issue_rs1_ready_i = 1'b0;
    issue_rs1_rob_idx_i = '0;
    issue_rs1_value_i = '0;
    issue_rs2_ready_i = 1'b0;
    issue_rs2_rob_idx_i = '0;
    issue_rs2_value_i = '0;
    issue_dest_rob_idx_i = '0;
    cdb_valid_i = 1'b0;
    cdb_rob_idx_i = '0;
    cdb_value_i = '0;
    cdb_ready_i = 1'b1;
    wake_hold = 1'b0;
    hold_check = 1'b0;
    errors = 0;
    errors_before = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    end_test("reset state");

    issue_instr(4'd0, 4'd1, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    issue_instr(4'd1, 4'd2, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    issue_instr(4'hf, 4'd3, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    wait_writeback(4'd1);
    wait_writeback(4'd2);
    wait_writeback(4'd3);
    end_test("operands ready at issue");

    // Both operands from the CDB input, then one from a unit result
    wake_a = rand_word();
    wake_b = rand_word();
    issue_instr(4'd0, 4'd4, 1'b0, 4'd9, wake_a, 1'b0, 4'd10, wake_b);
    wake_hold <= 1'b1;
    repeat (3) @(posedge clk_i);
    broadcast(4'd9, wake_a);
    repeat (3) @(posedge clk_i);
    wake_hold <= 1'b0;
    broadcast(4'd10, wake_b);
    wait_writeback(4'd4);
    issue_instr(4'd0, 4'd5, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    issue_instr(4'd1, 4'd6, 1'b0, 4'd5, exp_value[5], 1'b1, 4'd0, rand_word());
    wait_writeback(4'd5);
    wait_writeback(4'd6);
    end_test("operand wakeup");

    @(posedge clk_i);
    cdb_ready_i <= 1'b0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      issue_instr(eu_ctl_t'(rand_word()), rob_idx_t'(7 + i), 1'b1, 4'd0, rand_word(),
                  1'b1, 4'd0, rand_word());
    end
    repeat (10) @(posedge clk_i);
    cdb_ready_i <= 1'b1;
    for (int i = 0; i < RS_DEPTH; i++) begin
      wait_writeback(rob_idx_t'(7 + i));
    end
    end_test("full station");

    @(posedge clk_i);
    cdb_ready_i <= 1'b0;
    issue_instr(4'd1, 4'd13, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    wait_cdb_valid();
    hold_check <= 1'b1;
    repeat (5) @(posedge clk_i);
    hold_check  <= 1'b0;
    cdb_ready_i <= 1'b1;
    wait_writeback(4'd13);
    end_test("CDB back-pressure");

    // One completed entry held back, one stuck on a tag never sent
    @(posedge clk_i);
    cdb_ready_i <= 1'b0;
    issue_instr(4'd0, 4'd14, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    issue_instr(4'd0, 4'd15, 1'b0, 4'd9, rand_word(), 1'b1, 4'd0, rand_word());
    wait_cdb_valid();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i     <= 1'b0;
    cdb_ready_i <= 1'b1;
    repeat (20) @(posedge clk_i);
    issue_instr(4'd1, 4'd0, 1'b1, 4'd0, rand_word(), 1'b1, 4'd0, rand_word());
    wait_writeback(4'd0);
    repeat (5) @(posedge clk_i);
    end_test("flush");

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

/* bench/tb_serial_eu.sv */
// ----------------------------------------------------------
// Behavioural serial execution unit for the station testbench.
// Takes one operation at a time, answers after 1 to 6 cycles.
// ----------------------------------------------------------

`timescale 1ns/10ps

module tb_serial_eu import rs_pkg::*; #(
  parameter int SEED = 82
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         req_valid_i,      // Station offers an entry
  output logic         req_ready_o,
  input  eu_ctl_t      ctl_i,
  input  xlen_t        rs1_i,
  input  xlen_t        rs2_i,
  input  rob_idx_t     rob_idx_i,
  output logic         res_valid_o,
  output rob_idx_t     res_rob_idx_o,
  output xlen_t        res_value_o,
  output logic         except_raised_o,
  output except_code_t except_code_o
);

  localparam int           LAT_MIN  = 1;
  localparam int           LAT_MAX  = 6;
  localparam eu_ctl_t      EXC_CTL  = 4'hf;
  localparam except_code_t EXC_CODE = 5'd2;

  int       seed;
  int       lat_cnt;    // Cycles left, zero when idle
  logic     sample_q;   // Held operands valid this cycle
  xlen_t    res_q;
  rob_idx_t tag_q;
  logic     exc_q;

  // Control bit 0 selects subtract
  function automatic xlen_t execute_op(input eu_ctl_t ctl, input xlen_t a, input xlen_t b);
    if (ctl[0]) begin
      return a - b;
    end
    return a + b;
  endfunction

  initial begin
    seed            = SEED;
    req_ready_o     = 1'b1;
    res_valid_o     = 1'b0;
    res_rob_idx_o   = '0;
    res_value_o     = '0;
    except_raised_o = 1'b0;
    except_code_o   = '0;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_ready_o <= 1'b1;
      sample_q    <= 1'b0;
      lat_cnt     <= 0;
      res_valid_o <= 1'b0;
    end else if (flush_i) begin  // Operation in flight is dropped
      req_ready_o <= 1'b1;
      sample_q    <= 1'b0;
      lat_cnt     <= 0;
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= 1'b0;
      if (req_valid_i && req_ready_o) begin
        req_ready_o <= 1'b0;
        sample_q    <= 1'b1;
      end else if (sample_q) begin
        sample_q <= 1'b0;
        res_q    <= execute_op(ctl_i, rs1_i, rs2_i);
        tag_q    <= rob_idx_i;
        exc_q    <= ctl_i == EXC_CTL;
        lat_cnt  <= LAT_MIN + int'($unsigned($random(seed)) % (LAT_MAX - LAT_MIN + 1));
      end else if (lat_cnt == 1) begin
        res_valid_o     <= 1'b1;
        res_rob_idx_o   <= tag_q;
        res_value_o     <= res_q;
        except_raised_o <= exc_q;
        except_code_o   <= exc_q ? EXC_CODE : '0;
        lat_cnt         <= 0;
        req_ready_o     <= 1'b1;   // Free again with the result
      end else if (lat_cnt > 1) begin
        lat_cnt <= lat_cnt - 1;
      end
    end
  end

endmodule

/* design/rs_dispatch.sv */
// ----------------------------------------------------------
// Execute selector. Offers the lowest requesting entry to the
// serial unit and holds the accepted index so its operands stay
// stable for the whole execution.
// ----------------------------------------------------------

`timescale 1ns/10ps

module rs_dispatch import rs_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                flush_i,
  input  logic [RS_DEPTH-1:0] ex_req_i,
  input  logic                eu_ready_i,
  input  eu_ctl_t             ctl_i     [RS_DEPTH],
  input  xlen_t               rs1_i     [RS_DEPTH],
  input  xlen_t               rs2_i     [RS_DEPTH],
  input  rob_idx_t            rob_idx_i [RS_DEPTH],
  output logic                eu_valid_o,
  output rs_idx_t             ex_idx_o,
  output logic                accepted_o,
  output eu_ctl_t             eu_ctl_o,
  output xlen_t               eu_rs1_o,
  output xlen_t               eu_rs2_o,
  output rob_idx_t            eu_rob_idx_o
);

  rs_idx_t ex_idx;
  rs_idx_t hold_idx_q;

  rs_prio_enc u_ex_sel (
    .req_i   (ex_req_i),
    .idx_o   (ex_idx),
    .valid_o (eu_valid_o)
  );

  assign ex_idx_o   = ex_idx;
  assign accepted_o = eu_valid_o & eu_ready_i;

  // Held until the next accept
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_idx_q <= '0;
    end else if (flush_i) begin
      hold_idx_q <= '0;
    end else if (accepted_o) begin
      hold_idx_q <= ex_idx;
    end
  end

  // Operands of the entry in execution
  assign eu_ctl_o     = ctl_i[hold_idx_q];
  assign eu_rs1_o     = rs1_i[hold_idx_q];
  assign eu_rs2_o     = rs2_i[hold_idx_q];
  assign eu_rob_idx_o = rob_idx_i[hold_idx_q];

endmodule

/* design/rs_entry.sv */
// ----------------------------------------------------------
// One reservation station slot. Holds the instruction fields,
// snoops the CDB and unit result for missing operands, and keeps
// the result until the CDB writeback removes it.
// ----------------------------------------------------------

`timescale 1ns/10ps

module rs_entry import rs_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,

  // Strobes decoded by the top
  input  logic         insert_i,
  input  logic         accepted_i,
  input  logic         removed_i,

  // Issue stage
  input  eu_ctl_t      issue_eu_ctl_i,
  input  logic         issue_rs1_ready_i,
  input  rob_idx_t     issue_rs1_rob_idx_i,
  input  xlen_t        issue_rs1_value_i,
  input  logic         issue_rs2_ready_i,
  input  rob_idx_t     issue_rs2_rob_idx_i,
  input  xlen_t        issue_rs2_value_i,
  input  rob_idx_t     issue_dest_rob_idx_i,

  // CDB snoop
  input  logic         cdb_valid_i,
  input  rob_idx_t     cdb_rob_idx_i,
  input  xlen_t        cdb_value_i,

  // Unit result
  input  logic         eu_valid_i,
  input  rob_idx_t     eu_rob_idx_i,
  input  xlen_t        eu_result_i,
  input  logic         eu_except_raised_i,
  input  except_code_t eu_except_code_i,

  // State flags
  output logic         empty_o,
  output logic         ex_req_o,
  output logic         completed_o,

  // Stored fields
  output eu_ctl_t      eu_ctl_o,
  output xlen_t        rs1_value_o,
  output xlen_t        rs2_value_o,
  output rob_idx_t     dest_rob_idx_o,
  output xlen_t        res_value_o,
  output logic         except_raised_o,
  output except_code_t except_code_o
);

  entry_state_t state_q, state_d;

  eu_ctl_t      ctl_q;
  rob_idx_t     rs1_rob_idx_q, rs2_rob_idx_q, dest_rob_idx_q;
  xlen_t        rs1_value_q, rs2_value_q, res_value_q;
  logic         except_raised_q;
  except_code_t except_code_q;

  logic ins_fwd_rs1, ins_fwd_rs2;
  logic rs1_have, rs2_have;
  logic fwd_rs1_eu, fwd_rs2_eu, fwd_rs1_cdb, fwd_rs2_cdb;
  logic fwd_rs1, fwd_rs2;
  logic res_match;
  logic ld_issue, ld_rs1, ld_rs2, ld_res;

  // ----------------------------------------------------------
  // Tag compares
  // ----------------------------------------------------------
  // At insert only the unit result can supply a missing operand
  assign ins_fwd_rs1 = ~issue_rs1_ready_i & eu_valid_i & (eu_rob_idx_i == issue_rs1_rob_idx_i);
  assign ins_fwd_rs2 = ~issue_rs2_ready_i & eu_valid_i & (eu_rob_idx_i == issue_rs2_rob_idx_i);
  assign rs1_have    = issue_rs1_ready_i | ins_fwd_rs1;
  assign rs2_have    = issue_rs2_ready_i | ins_fwd_rs2;

  assign fwd_rs1_eu  = eu_valid_i & (eu_rob_idx_i == rs1_rob_idx_q);
  assign fwd_rs2_eu  = eu_valid_i & (eu_rob_idx_i == rs2_rob_idx_q);
  assign fwd_rs1_cdb = cdb_valid_i & (cdb_rob_idx_i == rs1_rob_idx_q);
  assign fwd_rs2_cdb = cdb_valid_i & (cdb_rob_idx_i == rs2_rob_idx_q);
  assign fwd_rs1     = fwd_rs1_eu | fwd_rs1_cdb;
  assign fwd_rs2     = fwd_rs2_eu | fwd_rs2_cdb;

  assign res_match   = eu_valid_i & (eu_rob_idx_i == dest_rob_idx_q);

  // ----------------------------------------------------------
  // Slot FSM
  // ----------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    ld_issue = 1'b0;
    ld_rs1   = 1'b0;
    ld_rs2   = 1'b0;
    ld_res   = 1'b0;
    unique case (state_q)
      EMPTY: begin
        if (insert_i) begin
          ld_issue = 1'b1;
          unique case ({rs1_have, rs2_have})
            2'b11:   state_d = EX_REQ;
            2'b01:   state_d = RS1_PENDING;
            2'b10:   state_d = RS2_PENDING;
            default: state_d = RS12_PENDING;
          endcase
        end
      end
      RS12_PENDING: begin
        ld_rs1 = fwd_rs1;
        ld_rs2 = fwd_rs2;
        if (fwd_rs1 && fwd_rs2) begin
          state_d = EX_REQ;
        end else if (fwd_rs1) begin
          state_d = RS2_PENDING;
        end else if (fwd_rs2) begin
          state_d = RS1_PENDING;
        end
      end
      RS1_PENDING: begin
        ld_rs1 = fwd_rs1;
        if (fwd_rs1) state_d = EX_REQ;
      end
      RS2_PENDING: begin
        ld_rs2 = fwd_rs2;
        if (fwd_rs2) state_d = EX_REQ;
      end
      EX_REQ: begin
        if (res_match) begin  // Result can beat the accept
          ld_res  = 1'b1;
          state_d = COMPLETED;
        end else if (accepted_i) begin
          state_d = EX_WAIT;
        end
      end
      EX_WAIT: begin
        if (res_match) begin
          ld_res  = 1'b1;
          state_d = COMPLETED;
        end
      end
      COMPLETED: begin
        if (removed_i) state_d = EMPTY;
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= EMPTY;
    end else if (flush_i) begin
      state_q <= EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------
  // Payload
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (ld_issue) begin
      ctl_q          <= issue_eu_ctl_i;
      rs1_rob_idx_q  <= issue_rs1_rob_idx_i;
      rs2_rob_idx_q  <= issue_rs2_rob_idx_i;
      dest_rob_idx_q <= issue_dest_rob_idx_i;
      rs1_value_q    <= issue_rs1_ready_i ? issue_rs1_value_i : eu_result_i;
      rs2_value_q    <= issue_rs2_ready_i ? issue_rs2_value_i : eu_result_i;
    end
    // Unit result wins over the CDB on a double match
    if (ld_rs1) rs1_value_q <= fwd_rs1_eu ? eu_result_i : cdb_value_i;
    if (ld_rs2) rs2_value_q <= fwd_rs2_eu ? eu_result_i : cdb_value_i;
    if (ld_res) begin
      res_value_q     <= eu_result_i;
      except_raised_q <= eu_except_raised_i;
      except_code_q   <= eu_except_code_i;
    end
  end

  // Flags and fields
  assign empty_o         = state_q == EMPTY;
  assign ex_req_o        = state_q == EX_REQ;
  assign completed_o     = state_q == COMPLETED;
  assign eu_ctl_o        = ctl_q;
  assign rs1_value_o     = rs1_value_q;
  assign rs2_value_o     = rs2_value_q;
  assign dest_rob_idx_o  = dest_rob_idx_q;
  assign res_value_o     = res_value_q;
  assign except_raised_o = except_raised_q;
  assign except_code_o   = except_code_q;

endmodule

/* design/rs_pkg.sv */
// ----------------------------------------------------------
// Shared sizes, value types and entry state encoding for the
// serial-unit reservation station. Imported by every RTL block.
// ----------------------------------------------------------

package rs_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int unsigned RS_DEPTH  = 4;                 // Station entries
  localparam int unsigned RS_IDX_W  = $clog2(RS_DEPTH);
  localparam int unsigned XLEN      = 32;                // Operand and result width
  localparam int unsigned ROB_IDX_W = 4;
  localparam int unsigned EU_CTL_W  = 4;
  localparam int unsigned EXCEPT_W  = 5;

  // ----------------------------------------------------------
  // Value types
  // ----------------------------------------------------------
  typedef logic [RS_IDX_W-1:0]  rs_idx_t;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;
  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [EU_CTL_W-1:0]  eu_ctl_t;
  typedef logic [EXCEPT_W-1:0]  except_code_t;

  // Per-entry state
  typedef enum logic [2:0] {
    EMPTY,         // Free slot
    RS1_PENDING,   // Waiting on rs1 only
    RS2_PENDING,   // Waiting on rs2 only
    RS12_PENDING,  // Waiting on both operands
    EX_REQ,        // Operands present, asking for the unit
    EX_WAIT,       // Accepted, unit busy with it
    COMPLETED      // Result held until CDB takes it
  } entry_state_t;

endpackage

/* design/rs_prio_enc.sv */
// ----------------------------------------------------------
// Lowest-index-first priority encoder over the station entries.
// Shared by the free-slot, execute and writeback selectors.
// ----------------------------------------------------------

`timescale 1ns/10ps

module rs_prio_enc import rs_pkg::*; (
  input  logic [RS_DEPTH-1:0] req_i,
  output rs_idx_t             idx_o,
  output logic                valid_o
);

  // Scan downwards so the lowest set line wins
  always_comb begin
    idx_o = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (req_i[i]) begin
        idx_o = rs_idx_t'(i);
      end
    end
  end

  assign valid_o = |req_i;

endmodule

/* design/rs_serial_top.sv */
// ----------------------------------------------------------
// Reservation station for one serial execution unit. Four slots
// fed by the issue stage, dispatched by fixed priority and
// written back over the CDB. Flush empties every slot.
// ----------------------------------------------------------

`timescale 1ns/10ps

module rs_serial_top import rs_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,

  // Issue stage
  input  logic         issue_valid_i,
  output logic         issue_ready_o,
  input  eu_ctl_t      issue_eu_ctl_i,
  input  logic         issue_rs1_ready_i,
  input  rob_idx_t     issue_rs1_rob_idx_i,
  input  xlen_t        issue_rs1_value_i,
  input  logic         issue_rs2_ready_i,
  input  rob_idx_t     issue_rs2_rob_idx_i,
  input  xlen_t        issue_rs2_value_i,
  input  rob_idx_t     issue_dest_rob_idx_i,

  // CDB
  input  logic         cdb_valid_i,
  input  rob_idx_t     cdb_rob_idx_i,
  input  xlen_t        cdb_value_i,
  input  logic         cdb_ready_i,
  output logic         cdb_valid_o,
  output rob_idx_t     cdb_rob_idx_o,
  output xlen_t        cdb_value_o,
  output logic         cdb_except_raised_o,
  output except_code_t cdb_except_code_o,

  // Execution unit
  input  logic         eu_ready_i,
  output logic         eu_valid_o,
  output eu_ctl_t      eu_ctl_o,
  output xlen_t        eu_rs1_o,
  output xlen_t        eu_rs2_o,
  output rob_idx_t     eu_rob_idx_o,
  input  logic         eu_valid_i,
  input  rob_idx_t     eu_rob_idx_i,
  input  xlen_t        eu_result_i,
  input  logic         eu_except_raised_i,
  input  except_code_t eu_except_code_i
);

  // ----------------------------------------------------------
  // Per-slot flags, strobes and fields
  // ----------------------------------------------------------
  logic [RS_DEPTH-1:0] empty, ex_req, completed;
  logic [RS_DEPTH-1:0] insert, accepted, removed;  // One-hot strobes

  eu_ctl_t      ctl           [RS_DEPTH];
  xlen_t        rs1_value     [RS_DEPTH];
  xlen_t        rs2_value     [RS_DEPTH];
  rob_idx_t     dest_rob_idx  [RS_DEPTH];
  xlen_t        res_value     [RS_DEPTH];
  logic         except_raised [RS_DEPTH];
  except_code_t except_code   [RS_DEPTH];

  rs_idx_t free_idx, ex_idx, wb_idx;
  logic    issue_fire, ex_accept, wb_remove;

  // Lowest empty slot takes the next instruction
  rs_prio_enc u_free_sel (
    .req_i   (empty),
    .idx_o   (free_idx),
    .valid_o (issue_ready_o)
  );

  assign issue_fire = issue_valid_i & issue_ready_o;

  for (genvar i = 0; i < RS_DEPTH; i++) begin : g_slot
    assign insert[i]   = issue_fire & (free_idx == rs_idx_t'(i));
    assign accepted[i] = ex_accept & (ex_idx == rs_idx_t'(i));
    assign removed[i]  = wb_remove & (wb_idx == rs_idx_t'(i));

    rs_entry u_entry (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .flush_i              (flush_i),
      .insert_i             (insert[i]),
      .accepted_i           (accepted[i]),
      .removed_i            (removed[i]),
      .issue_eu_ctl_i       (issue_eu_ctl_i),
      .issue_rs1_ready_i    (issue_rs1_ready_i),
      .issue_rs1_rob_idx_i  (issue_rs1_rob_idx_i),
      .issue_rs1_value_i    (issue_rs1_value_i),
      .issue_rs2_ready_i    (issue_rs2_ready_i),
      .issue_rs2_rob_idx_i  (issue_rs2_rob_idx_i),
      .issue_rs2_value_i    (issue_rs2_value_i),
      .issue_dest_rob_idx_i (issue_dest_rob_idx_i),
      .cdb_valid_i          (cdb_valid_i),
      .cdb_rob_idx_i        (cdb_rob_idx_i),
      .cdb_value_i          (cdb_value_i),
      .eu_valid_i           (eu_valid_i),
      .eu_rob_idx_i         (eu_rob_idx_i),
      .eu_result_i          (eu_result_i),
      .eu_except_raised_i   (eu_except_raised_i),
      .eu_except_code_i     (eu_except_code_i),
      .empty_o              (empty[i]),
      .ex_req_o             (ex_req[i]),
      .completed_o          (completed[i]),
      .eu_ctl_o             (ctl[i]),
      .rs1_value_o          (rs1_value[i]),
      .rs2_value_o          (rs2_value[i]),
      .dest_rob_idx_o       (dest_rob_idx[i]),
      .res_value_o          (res_value[i]),
      .except_raised_o      (except_raised[i]),
      .except_code_o        (except_code[i])
    );
  end

  // ----------------------------------------------------------
  // Execute and writeback selectors
  // ----------------------------------------------------------
  rs_dispatch u_dispatch (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .ex_req_i     (ex_req),
    .eu_ready_i   (eu_ready_i),
    .ctl_i        (ctl),
    .rs1_i        (rs1_value),
    .rs2_i        (rs2_value),
    .rob_idx_i    (dest_rob_idx),
    .eu_valid_o   (eu_valid_o),
    .ex_idx_o     (ex_idx),
    .accepted_o   (ex_accept),
    .eu_ctl_o     (eu_ctl_o),
    .eu_rs1_o     (eu_rs1_o),
    .eu_rs2_o     (eu_rs2_o),
    .eu_rob_idx_o (eu_rob_idx_o)
  );

  rs_writeback u_writeback (
    .completed_i         (completed),
    .cdb_ready_i         (cdb_ready_i),
    .rob_idx_i           (dest_rob_idx),
    .value_i             (res_value),
    .except_raised_i     (except_raised),
    .except_code_i       (except_code),
    .cdb_valid_o         (cdb_valid_o),
    .cdb_idx_o           (wb_idx),
    .removed_o           (wb_remove),
    .cdb_rob_idx_o       (cdb_rob_idx_o),
    .cdb_value_o         (cdb_value_o),
    .cdb_except_raised_o (cdb_except_raised_o),
    .cdb_except_code_o   (cdb_except_code_o)
  );

endmodule

/* design/rs_writeback.sv */
// ----------------------------------------------------------
// CDB writeback selector. Puts the lowest completed entry on the
// CDB outputs and flags its removal when the bus takes it.
// ----------------------------------------------------------

`timescale 1ns/10ps

module rs_writeback import rs_pkg::*; (
  input  logic [RS_DEPTH-1:0] completed_i,
  input  logic                cdb_ready_i,
  input  rob_idx_t            rob_idx_i       [RS_DEPTH],
  input  xlen_t               value_i         [RS_DEPTH],
  input  logic                except_raised_i [RS_DEPTH],
  input  except_code_t        except_code_i   [RS_DEPTH],
  output logic                cdb_valid_o,
  output rs_idx_t             cdb_idx_o,
  output logic                removed_o,
  output rob_idx_t            cdb_rob_idx_o,
  output xlen_t               cdb_value_o,
  output logic                cdb_except_raised_o,
  output except_code_t        cdb_except_code_o
);

  rs_idx_t wb_idx;

  rs_prio_enc u_wb_sel (
    .req_i   (completed_i),
    .idx_o   (wb_idx),
    .valid_o (cdb_valid_o)
  );

  assign cdb_idx_o = wb_idx;
  assign removed_o = cdb_valid_o & cdb_ready_i;  // Bus takes it this edge

  // Result of the selected entry
  assign cdb_rob_idx_o       = rob_idx_i[wb_idx];
  assign cdb_value_o         = value_i[wb_idx];
  assign cdb_except_raised_o = except_raised_i[wb_idx];
  assign cdb_except_code_o   = except_code_i[wb_idx];

endmodule

/* verilog.f */
design/rs_pkg.sv
design/rs_prio_enc.sv
design/rs_entry.sv
design/rs_dispatch.sv
design/rs_writeback.sv
design/rs_serial_top.sv
bench/tb_serial_eu.sv
bench/tb_rs_serial.sv
